//--- hdl/core88_pkg.sv
package core88_pkg;

    // ==================================================
    // Basic types
    // ==================================================
    typedef logic [19:0] addr_t;
    typedef logic [15:0] word_t;

    // Matches opcode bits 5:3 of the ALU group
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_OR  = 3'd1,
        ALU_ADC = 3'd2,
        ALU_SBB = 3'd3,
        ALU_AND = 3'd4,
        ALU_SUB = 3'd5,
        ALU_XOR = 3'd6,
        ALU_CMP = 3'd7
    } alu_op_e;

    // CF sits in bit 0 as in the x86 flags word
    typedef struct packed {
        logic of;
        logic sf;
        logic zf;
        logic af;
        logic pf;
        logic cf;
    } flags_t;

    // ==================================================
    // Bus and control bundles
    // ==================================================
    typedef struct packed {
        logic       req;
        logic       write;
        word_t      seg;
        word_t      offset;
        logic [7:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic take;
        logic branch;
    } code_ctl_t;

    typedef struct packed {
        logic  push;
        logic  pop;
        word_t value;
    } stack_cmd_t;

    localparam word_t RESET_CS = 16'hF000;

    // Opcode classes of the supported subset
    typedef enum logic [3:0] {
        CL_NOP,
        CL_ALU_IMM,
        CL_INC,
        CL_DEC,
        CL_PUSH,
        CL_POP,
        CL_JCC,
        CL_MOV_IMM,
        CL_JMP8,
        CL_FLAG
    } op_class_e;

    function automatic op_class_e op_class(logic [7:0] op);
        casez (op)
            8'b00???10?: return CL_ALU_IMM;
            8'b01000???: return CL_INC;
            8'b01001???: return CL_DEC;
            8'b01010???: return CL_PUSH;
            8'b01011???: return CL_POP;
            8'b0111????: return CL_JCC;
            8'b1011????: return CL_MOV_IMM;
            8'hEB:       return CL_JMP8;
            8'hF5, 8'hF8, 8'hF9: return CL_FLAG;
            // Anything else runs as a one-byte no-op
            default:     return CL_NOP;
        endcase
    endfunction

endpackage

//--- hdl/alu16.sv
`timescale 1ns/1ps

module alu16 import core88_pkg::*; (
    input  alu_op_e op,
    input  logic    wide,
    input  word_t   a,
    input  word_t   b,
    input  flags_t  flags_in,
    output word_t   result,
    output flags_t  flags_out
);

    logic       sub;
    logic       cin;
    logic       arith;
    word_t      b_eff;
    logic [8:0] sum_lo;
    logic [8:0] sum_hi;
    logic       carry;
    logic       a_msb;
    logic       b_msb;
    logic       r_msb;

    always_comb begin
        sub   = (op == ALU_SUB) || (op == ALU_SBB) || (op == ALU_CMP);
        cin   = ((op == ALU_ADC) || (op == ALU_SBB)) && flags_in.cf;
        arith = !((op == ALU_OR) || (op == ALU_AND) || (op == ALU_XOR));

        // Subtraction as a + ~b + 1, borrow folds into the carry in
        b_eff  = sub ? ~b : b;
        sum_lo = {1'b0, a[7:0]} + {1'b0, b_eff[7:0]} + {8'h00, cin ^ sub};
        sum_hi = {1'b0, a[15:8]} + {1'b0, b_eff[15:8]} + {8'h00, sum_lo[8]};
        carry  = wide ? sum_hi[8] : sum_lo[8];

        case (op)
            ALU_OR:  result = a | b;
            ALU_AND: result = a & b;
            ALU_XOR: result = a ^ b;
            default: result = {sum_hi[7:0], sum_lo[7:0]};
        endcase

        a_msb = wide ? a[15] : a[7];
        b_msb = wide ? b_eff[15] : b_eff[7];
        r_msb = wide ? result[15] : result[7];

        // ==================================================
        // Flags
        // ==================================================
        flags_out.zf = wide ? (result == 16'h0000) : (result[7:0] == 8'h00);
        flags_out.sf = r_msb;
        flags_out.pf = ~^result[7:0];

        // Logic operations clear CF, OF and AF
        flags_out.cf = arith && (carry ^ sub);
        flags_out.af = arith && (a[4] ^ b[4] ^ result[4]);
        flags_out.of = arith && (a_msb == b_msb) && (r_msb != a_msb);
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import core88_pkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  logic       locked,
    input  logic [2:0] rd_index,
    input  logic       rd_wide,
    output word_t      rd_value,
    input  logic       wr_en,
    input  logic [2:0] wr_index,
    input  logic       wr_wide,
    input  word_t      wr_value,
    input  logic       sp_down,
    input  logic       sp_up,
    output word_t      sp
);

    // AX, CX, DX, BX, SP, BP, SI, DI
    word_t regs [8];
    word_t rd_pair;

    // Byte index 0-3 is the low half, 4-7 the high half of AX..BX
    assign rd_pair  = regs[{1'b0, rd_index[1:0]}];
    assign rd_value = rd_wide ? regs[rd_index]
                    : {8'h00, rd_index[2] ? rd_pair[15:8] : rd_pair[7:0]};
    assign sp = regs[4];

    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (locked) begin
            if (sp_down) regs[4] <= regs[4] - 16'd2;
            else if (sp_up) regs[4] <= regs[4] + 16'd2;

            if (wr_en) begin
                if (wr_wide) regs[wr_index] <= wr_value;
                else if (wr_index[2]) regs[{1'b0, wr_index[1:0]}][15:8] <= wr_value[7:0];
                else regs[{1'b0, wr_index[1:0]}][7:0] <= wr_value[7:0];
            end
        end
    end

endmodule

//--- hdl/code_fetch.sv
`timescale 1ns/1ps

module code_fetch import core88_pkg::*; #(
    parameter word_t RESET_CS = core88_pkg::RESET_CS
) (
    input  logic       clock,
    input  logic       resetn,
    input  logic       locked,
    input  code_ctl_t  ctl,
    input  logic [7:0] bus,
    input  logic       granted,
    output mem_req_t   code_req,
    output logic [7:0] code_byte
);

    word_t cs;
    word_t ip;
    word_t rel;

    // Always reading at CS:IP, the arbiter decides who gets the bus
    assign code_req = '{req: 1'b1, write: 1'b0, seg: cs, offset: ip, wdata: 8'h00};
    assign code_byte = bus;

    // Sign-extended displacement for short jumps
    assign rel = ctl.branch ? {{8{bus[7]}}, bus} : 16'h0000;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            cs <= RESET_CS;
            ip <= 16'h0000;
        end else if (locked && ctl.take) begin
            ip <= ip + 16'd1 + rel;
        end
    end

    // The sequencer must never consume a byte owned by the stack port
    assert property (@(posedge clock) disable iff (!resetn)
        (locked && ctl.take) |-> granted)
    else $error("code byte taken while the stack port holds the bus");

endmodule

//--- hdl/stack_port.sv
`timescale 1ns/1ps

module stack_port import core88_pkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  logic       locked,
    input  stack_cmd_t cmd,
    input  word_t      sp,
    input  logic [7:0] bus,
    output mem_req_t   stack_req,
    output logic       sp_down,
    output logic       sp_up,
    output logic       stack_done,
    output word_t      pop_value
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PUSH_HI,
        ST_POP_HI
    } stack_state_e;

    stack_state_e state;
    word_t        ss;
    logic [7:0]   push_hi;

    // ==================================================
    // Byte requests on SS:SP
    // ==================================================
    always_comb begin
        stack_req     = '0;
        stack_req.seg = ss;
        sp_down       = 1'b0;
        sp_up         = 1'b0;
        stack_done    = 1'b0;
        case (state)
            ST_IDLE: begin
                if (cmd.push) begin
                    // Low byte at SP-2, SP moves down this cycle
                    stack_req.req    = 1'b1;
                    stack_req.write  = 1'b1;
                    stack_req.offset = sp - 16'd2;
                    stack_req.wdata  = cmd.value[7:0];
                    sp_down          = 1'b1;
                end else if (cmd.pop) begin
                    stack_req.req    = 1'b1;
                    stack_req.offset = sp;
                end
            end
            ST_PUSH_HI: begin
                // SP already lowered, so SP+1 is the old SP-1
                stack_req.req    = 1'b1;
                stack_req.write  = 1'b1;
                stack_req.offset = sp + 16'd1;
                stack_req.wdata  = push_hi;
                stack_done       = 1'b1;
            end
            ST_POP_HI: begin
                stack_req.req    = 1'b1;
                stack_req.offset = sp + 16'd1;
                sp_up            = 1'b1;
                stack_done       = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= ST_IDLE;
            ss    <= 16'h0000;
        end else if (locked) begin
            case (state)
                ST_IDLE: begin
                    if (cmd.push) state <= ST_PUSH_HI;
                    else if (cmd.pop) state <= ST_POP_HI;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Data bytes of the running sequence
    always_ff @(posedge clock) begin
        if (locked) begin
            if (state == ST_IDLE && cmd.push) push_hi <= cmd.value[15:8];
            if (state == ST_IDLE && cmd.pop) pop_value[7:0] <= bus;
            if (state == ST_POP_HI) pop_value[15:8] <= bus;
        end
    end

    assert property (@(posedge clock) disable iff (!resetn) !(cmd.push && cmd.pop))
    else $error("push and pop requested together");

endmodule

//--- hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import core88_pkg::*; (
    input  mem_req_t   code_req,
    input  mem_req_t   stack_req,
    output logic       code_granted,
    output addr_t      address,
    output logic [7:0] data,
    output logic       wreq
);

    mem_req_t grant;

    // Stack port wins whenever it asks
    assign code_granted = !stack_req.req;
    assign grant        = stack_req.req ? stack_req : code_req;

    // Real-mode address, segment times sixteen plus offset
    assign address = {grant.seg, 4'h0} + {4'h0, grant.offset};
    assign wreq    = grant.req && grant.write;
    assign data    = wreq ? grant.wdata : 8'h00;

    // Code space is read only in this core
    always_comb begin
        assert (!(code_req.req && code_req.write))
        else $error("write request from the code fetch port");
    end

endmodule

//--- hdl/sequencer.sv
`timescale 1ns/1ps

module sequencer import core88_pkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  logic       locked,
    input  logic [7:0] code_byte,
    input  logic       code_granted,
    output code_ctl_t  ctl,
    output stack_cmd_t cmd,
    input  logic       stack_done,
    input  word_t      pop_value,
    output logic [2:0] rd_index,
    output logic       rd_wide,
    input  word_t      rd_value,
    output logic       wr_en,
    output logic [2:0] wr_index,
    output logic       wr_wide,
    output word_t      wr_value,
    output alu_op_e    alu_op,
    output logic       alu_wide,
    output word_t      alu_a,
    output word_t      alu_b,
    output flags_t     alu_flags_in,
    input  word_t      alu_result,
    input  flags_t     alu_flags_out
);

    logic [7:0] opcode;
    logic [1:0] step;
    word_t      imm;
    flags_t     flags;

    op_class_e  cls;
    logic       imm_class;
    logic       stack_class;
    logic       needs_byte;
    logic       wide_imm;
    logic       cond;
    logic       jcc_taken;
    flags_t     incdec_flags;

    assign cls = op_class(opcode);

    // ==================================================
    // Decode and datapath steering
    // ==================================================
    always_comb begin
        imm_class   = (cls == CL_ALU_IMM) || (cls == CL_MOV_IMM);
        stack_class = (cls == CL_PUSH) || (cls == CL_POP);
        needs_byte  = imm_class || (cls == CL_JCC) || (cls == CL_JMP8);
        wide_imm    = (cls == CL_ALU_IMM) ? opcode[0] : opcode[3];

        // Accumulator for the ALU group, low opcode bits otherwise
        rd_index = (cls == CL_ALU_IMM) ? 3'd0 : opcode[2:0];
        rd_wide  = (cls == CL_ALU_IMM) ? opcode[0] : 1'b1;
        wr_index = rd_index;
        wr_wide  = (cls == CL_MOV_IMM) ? opcode[3] : rd_wide;
        if (cls == CL_MOV_IMM) wr_value = imm;
        else if (cls == CL_POP) wr_value = pop_value;
        else wr_value = alu_result;

        case (cls)
            CL_ALU_IMM: alu_op = alu_op_e'(opcode[5:3]);
            CL_DEC:     alu_op = ALU_SUB;
            default:    alu_op = ALU_ADD;
        endcase
        alu_wide     = rd_wide;
        alu_a        = rd_value;
        alu_b        = (cls == CL_ALU_IMM) ? imm : 16'd1;
        alu_flags_in = flags;

        // INC and DEC leave CF alone
        incdec_flags    = alu_flags_out;
        incdec_flags.cf = flags.cf;

        case (opcode[3:1])
            3'd0: cond = flags.of;
            3'd1: cond = flags.cf;
            3'd2: cond = flags.zf;
            3'd3: cond = flags.cf || flags.zf;
            3'd4: cond = flags.sf;
            3'd5: cond = flags.pf;
            3'd6: cond = flags.sf ^ flags.of;
            default: cond = (flags.sf ^ flags.of) || flags.zf;
        endcase
        jcc_taken = cond ^ opcode[0];

        ctl       = '0;
        cmd       = '0;
        cmd.value = rd_value;
        wr_en     = 1'b0;
        case (step)
            2'd0: ctl.take = code_granted;
            2'd1: begin
                ctl.take   = needs_byte && code_granted;
                ctl.branch = (cls == CL_JMP8) || ((cls == CL_JCC) && jcc_taken);
                cmd.push   = (cls == CL_PUSH);
                cmd.pop    = (cls == CL_POP);
                wr_en      = (cls == CL_INC) || (cls == CL_DEC);
            end
            2'd2: ctl.take = imm_class && code_granted;
            default: begin
                // Write-back step, CMP only touches the flags
                wr_en = (cls == CL_MOV_IMM) || (cls == CL_POP)
                     || ((cls == CL_ALU_IMM) && (alu_op != ALU_CMP));
            end
        endcase
    end

    // ==================================================
    // Step counter and flags
    // ==================================================
    always_ff @(posedge clock) begin
        if (!resetn) begin
            step  <= 2'd0;
            flags <= '0;
        end else if (locked) begin
            case (step)
                2'd0: if (code_granted) step <= 2'd1;
                2'd1: begin
                    if (!needs_byte || code_granted) begin
                        if (imm_class) step <= wide_imm ? 2'd2 : 2'd3;
                        else if (stack_class) step <= 2'd2;
                        else step <= 2'd0;
                    end
                    if (cls == CL_INC || cls == CL_DEC) flags <= incdec_flags;
                    if (cls == CL_FLAG) flags.cf <= (opcode == 8'hF5) ? ~flags.cf : opcode[0];
                end
                2'd2: begin
                    if (stack_class) begin
                        if (stack_done) step <= (cls == CL_POP) ? 2'd3 : 2'd0;
                    end else if (code_granted) begin
                        step <= 2'd3;
                    end
                end
                default: begin
                    if (cls == CL_ALU_IMM) flags <= alu_flags_out;
                    step <= 2'd0;
                end
            endcase
        end
    end

    // Opcode and immediate bytes
    always_ff @(posedge clock) begin
        if (locked && code_granted) begin
            if (step == 2'd0) opcode <= code_byte;
            if (step == 2'd1 && imm_class) imm <= {8'h00, code_byte};
            if (step == 2'd2 && imm_class) imm[15:8] <= code_byte;
        end
    end

endmodule

//--- hdl/core88.sv
`timescale 1ns/1ps

module core88 import core88_pkg::*; #(
    parameter word_t RESET_CS = core88_pkg::RESET_CS
) (
    input  logic       clock,
    input  logic       resetn,
    input  logic       locked,
    output addr_t      address,
    input  logic [7:0] bus,
    output logic [7:0] data,
    output logic       wreq
);

    mem_req_t   code_req;
    mem_req_t   stack_req;
    logic       code_granted;
    logic [7:0] code_byte;
    code_ctl_t  ctl;
    stack_cmd_t cmd;
    logic       stack_done;
    word_t      pop_value;
    word_t      sp;
    logic       sp_down;
    logic       sp_up;

    logic [2:0] rd_index;
    logic       rd_wide;
    word_t      rd_value;
    logic       wr_en;
    logic [2:0] wr_index;
    logic       wr_wide;
    word_t      wr_value;

    alu_op_e    alu_op;
    logic       alu_wide;
    word_t      alu_a;
    word_t      alu_b;
    flags_t     alu_flags_in;
    word_t      alu_result;
    flags_t     alu_flags_out;

    sequencer seq_i (
        .clock, .resetn, .locked,
        .code_byte, .code_granted,
        .ctl, .cmd,
        .stack_done, .pop_value,
        .rd_index, .rd_wide, .rd_value,
        .wr_en, .wr_index, .wr_wide, .wr_value,
        .alu_op, .alu_wide, .alu_a, .alu_b, .alu_flags_in,
        .alu_result, .alu_flags_out
    );

    code_fetch #(.RESET_CS(RESET_CS)) fetch_i (
        .clock, .resetn, .locked,
        .ctl, .bus,
        .granted (code_granted),
        .code_req, .code_byte
    );

    stack_port stack_i (
        .clock, .resetn, .locked,
        .cmd, .sp, .bus,
        .stack_req, .sp_down, .sp_up,
        .stack_done, .pop_value
    );

    bus_arbiter arb_i (
        .code_req, .stack_req,
        .code_granted,
        .address, .data, .wreq
    );

    alu16 alu_i (
        .op        (alu_op),
        .wide      (alu_wide),
        .a         (alu_a),
        .b         (alu_b),
        .flags_in  (alu_flags_in),
        .result    (alu_result),
        .flags_out (alu_flags_out)
    );

    reg_file regs_i (
        .clock, .resetn, .locked,
        .rd_index, .rd_wide, .rd_value,
        .wr_en, .wr_index, .wr_wide, .wr_value,
        .sp_down, .sp_up, .sp
    );

endmodule

//--- tests/mem_model.sv
`timescale 1ns/1ps

module mem_model import core88_pkg::*; (
    input  logic       clock,
    input  logic       load_en,
    input  addr_t      load_addr,
    input  logic [7:0] load_data,
    input  addr_t      address,
    input  logic       wreq,
    input  logic [7:0] data,
    output logic [7:0] bus
);

    // Full 20-bit physical space, one byte per address
    logic [7:0] mem [1 << 20];

    // Background pattern built from all three address bytes
    function automatic logic [7:0] fill_byte(addr_t a);
        return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]} ^ 8'h5A;
    endfunction

    initial begin
        for (int i = 0; i < (1 << 20); i++) begin
            mem[i] = fill_byte(addr_t'(i));
        end
    end

    // Read data follows the address in the same cycle
    assign bus = mem[address];

    // Program load port has priority over core writes
    always @(posedge clock) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (wreq) begin
            mem[address] <= data;
        end
    end

endmodule

//--- tests/tb_core88.sv
`timescale 1ns/1ps

module tb_core88 import core88_pkg::*; ();

    logic       clock;
    logic       resetn;
    logic       locked;
    addr_t      address;
    logic [7:0] bus;
    logic [7:0] data;
    logic       wreq;
    logic       load_en;
    addr_t      load_addr;
    logic [7:0] load_data;

    string      test_name;
    int         errors;
    int         cycles = 0;
    int         cycle_limit;
    int         idle_left;
    logic       idle_on;
    logic       reset_seen = 1'b0;

    // Reference model state
    word_t      ref_regs [8];
    logic       cf;
    logic       pf;
    logic       zf;
    logic       sf;
    logic       of;
    logic [7:0] stack_mem [65536];
    logic [7:0] prog [$];
    addr_t      exp_addr_q [$];
    logic [7:0] exp_data_q [$];
    int         n_instr;

    // Head of the write queue, stable across each rising edge
    logic       exp_valid;
    addr_t      exp_addr;
    logic [7:0] exp_data;
    logic       pending;

    core88 dut_i (
        .clock, .resetn, .locked,
        .address, .bus, .data, .wreq
    );

    mem_model mem_i (
        .clock, .load_en, .load_addr, .load_data,
        .address, .wreq, .data, .bus
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // Watchdog sized by each program's instruction count
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the expected writes never completed", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ==================================================
    // Assertions
    // ==================================================
    always @(posedge clock) reset_seen <= !resetn;

    assert property (@(posedge clock) (!resetn && reset_seen) |-> !wreq)
    else begin
        errors++;
        $display("%s: write request raised while the core is held in reset", test_name);
    end

    assert property (@(posedge clock) $rose(resetn) |-> (address == 20'hF0000))
    else begin
        errors++;
        $display("ERROR %s reset address expected %05h actual %05h",
                 test_name, 20'hF0000, $sampled(address));
    end

    assert property (@(posedge clock) disable iff (!resetn)
        (locked && wreq) |-> (exp_valid && address == exp_addr && data == exp_data))
    else begin
        errors++;
        if (!exp_valid) begin
            $display("%s: the core wrote %02h to %05h when no write was due",
                     test_name, $sampled(data), $sampled(address));
        end else begin
            $display("ERROR %s write expected %02h@%05h actual %02h@%05h", test_name,
                     exp_data, exp_addr, $sampled(data), $sampled(address));
        end
    end

    // ==================================================
    // Program builder and reference model
    // ==================================================
    function automatic void emit(logic [7:0] b);
        prog.push_back(b);
    endfunction

    // SS stays zero, so the physical address is the offset
    function automatic void expect_write(word_t offset, logic [7:0] b);
        exp_addr_q.push_back({4'h0, offset});
        exp_data_q.push_back(b);
    endfunction

    function automatic int sext(int unsigned v, bit wide);
        if (wide) return v[15] ? int'(v) - 65536 : int'(v);
        return v[7] ? int'(v) - 256 : int'(v);
    endfunction

    function automatic void set_szp(int unsigned r, bit wide);
        zf = wide ? (r[15:0] == 16'h0000) : (r[7:0] == 8'h00);
        sf = wide ? r[15] : r[7];
        pf = ($countones(r[7:0]) % 2) == 0;
    endfunction

    function automatic int pick_reg();
        int r;
        r = $urandom_range(0, 6);
        // Never SP
        return (r >= 4) ? r + 1 : r;
    endfunction

    function automatic void start_program();
        prog.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        n_instr = 0;
        for (int i = 0; i < 8; i++) begin
            ref_regs[i] = 16'h0000;
        end
        {cf, pf, zf, sf, of} = 5'b00000;
    endfunction

    function automatic void mov16(int r, word_t v);
        emit(8'hB8 | 8'(r));
        emit(v[7:0]);
        emit(v[15:8]);
        ref_regs[r] = v;
        n_instr++;
    endfunction

    function automatic void mov8(int r, logic [7:0] v);
        emit(8'hB0 | 8'(r));
        emit(v);
        if (r < 4) ref_regs[r][7:0] = v;
        else ref_regs[r - 4][15:8] = v;
        n_instr++;
    endfunction

    function automatic void push(int r);
        word_t v;
        v = ref_regs[r];
        emit(8'h50 | 8'(r));
        ref_regs[4] = ref_regs[4] - 16'd2;
        stack_mem[ref_regs[4]] = v[7:0];
        stack_mem[ref_regs[4] + 16'd1] = v[15:8];
        expect_write(ref_regs[4], v[7:0]);
        expect_write(ref_regs[4] + 16'd1, v[15:8]);
        n_instr++;
    endfunction

    function automatic void pop(int r);
        emit(8'h58 | 8'(r));
        ref_regs[r] = {stack_mem[ref_regs[4] + 16'd1], stack_mem[ref_regs[4]]};
        ref_regs[4] = ref_regs[4] + 16'd2;
        n_instr++;
    endfunction

    function automatic void alu_imm(int op, bit wide, word_t imm);
        int unsigned mask;
        int unsigned a;
        int unsigned b;
        int unsigned r;
        int          c;
        int          full;
        int          max;
        emit({2'b00, 3'(op), 2'b10, wide});
        emit(imm[7:0]);
        if (wide) emit(imm[15:8]);
        mask = wide ? 32'h0000FFFF : 32'h000000FF;
        max  = wide ? 32767 : 127;
        a = 32'(ref_regs[0]) & mask;
        b = 32'(imm) & mask;
        c = cf ? 1 : 0;
        case (op)
            0, 2: begin
                // ADD, ADC
                if (op == 0) c = 0;
                r = a + b + c;
                full = sext(a, wide) + sext(b, wide) + c;
                cf = r > mask;
            end
            3, 5, 7: begin
                // SBB, SUB, CMP
                if (op != 3) c = 0;
                r = a - b - c;
                full = sext(a, wide) - sext(b, wide) - c;
                cf = a < b + c;
            end
            default: begin
                r = (op == 1) ? (a | b) : (op == 4) ? (a & b) : (a ^ b);
                full = 0;
                cf = 1'b0;
            end
        endcase
        r = r & mask;
        of = (full > max) || (full < -max - 1);
        set_szp(r, wide);
        if (op != 7) begin
            if (wide) ref_regs[0] = r[15:0];
            else ref_regs[0][7:0] = r[7:0];
        end
        n_instr++;
    endfunction

    function automatic void incdec(int r, bit dec);
        int unsigned v;
        int          full;
        emit((dec ? 8'h48 : 8'h40) | 8'(r));
        v = 32'(ref_regs[r]);
        full = sext(v, 1'b1) + (dec ? -1 : 1);
        v = (dec ? v - 1 : v + 1) & 32'h0000FFFF;
        of = (full > 32767) || (full < -32768);
        set_szp(v, 1'b1);
        ref_regs[r] = v[15:0];
        n_instr++;
    endfunction

    function automatic void flag_op(int kind);
        case (kind)
            0: begin
                emit(8'hF8);
                cf = 1'b0;
            end
            1: begin
                emit(8'hF9);
                cf = 1'b1;
            end
            default: begin
                emit(8'hF5);
                cf = !cf;
            end
        endcase
        n_instr++;
    endfunction

    function automatic logic cond_holds(int cc);
        case (cc)
            0:  return of;
            1:  return !of;
            2:  return cf;
            3:  return !cf;
            4:  return zf;
            5:  return !zf;
            6:  return cf || zf;
            7:  return !cf && !zf;
            8:  return sf;
            9:  return !sf;
            10: return pf;
            11: return !pf;
            12: return sf != of;
            13: return sf == of;
            14: return zf || (sf != of);
            default: return !zf && (sf == of);
        endcase
    endfunction

    // Jcc over a one-byte trap PUSH
    function automatic void jcc_trap(int cc, int trap_r);
        logic taken;
        taken = cond_holds(cc);
        emit(8'h70 | 8'(cc));
        emit(8'h01);
        n_instr++;
        if (taken) emit(8'h50 | 8'(trap_r));
        else push(trap_r);
    endfunction

    function automatic void end_program();
        // JMP to itself
        emit(8'hEB);
        emit(8'hFE);
        n_instr++;
    endfunction

    // ==================================================
    // Instruction snippets
    // ==================================================
    function automatic void gen_mov_push();
        int r;
        if ($urandom_range(0, 1) == 0) begin
            r = pick_reg();
            mov16(r, 16'($urandom()));
        end else begin
            r = $urandom_range(0, 3);
            mov8(r, 8'($urandom()));
            mov8(r + 4, 8'($urandom()));
        end
        push(r);
    endfunction

    function automatic void gen_alu_chain();
        mov16(0, 16'($urandom()));
        repeat ($urandom_range(2, 6)) begin
            alu_imm($urandom_range(0, 7), 1'($urandom_range(0, 1)), 16'($urandom()));
        end
        push(0);
    endfunction

    function automatic void gen_carry_keep();
        flag_op($urandom_range(0, 2));
        incdec(pick_reg(), 1'($urandom_range(0, 1)));
        jcc_trap(2 + $urandom_range(0, 1), pick_reg());
    endfunction

    function automatic void gen_branch();
        if ($urandom_range(0, 1) == 0) begin
            flag_op($urandom_range(0, 2));
            jcc_trap(2, pick_reg());
        end else begin
            mov16(0, 16'($urandom()));
            alu_imm($urandom_range(0, 7), 1'($urandom_range(0, 1)), 16'($urandom()));
            jcc_trap($urandom_range(0, 15), pick_reg());
        end
    endfunction

    function automatic void gen_push_pop();
        int r1;
        int r2;
        r1 = pick_reg();
        r2 = pick_reg();
        mov16(r1, 16'($urandom()));
        push(r1);
        pop(r2);
        push(r2);
    endfunction

    // ==================================================
    // Run control
    // ==================================================
    task automatic track_writes();
        if (pending && exp_addr_q.size() > 0) begin
            exp_addr_q.delete(0);
            exp_data_q.delete(0);
        end
        exp_valid = exp_addr_q.size() > 0;
        if (exp_valid) begin
            exp_addr = exp_addr_q[0];
            exp_data = exp_data_q[0];
        end
        pending = resetn && locked && wreq;
    endtask

    task automatic step_cycle();
        @(posedge clock);
        if (idle_left > 0) begin
            locked <= 1'b0;
            idle_left--;
        end else if (idle_on && $urandom_range(0, 9) == 0) begin
            locked <= 1'b0;
            idle_left = $urandom_range(0, 4);
        end else begin
            locked <= 1'b1;
        end
        @(negedge clock);
        track_writes();
    endtask

    // Load under reset, release, then drain the write queue
    task automatic run_program();
        cycle_limit = cycles + prog.size() + 20 * n_instr + 200;
        @(posedge clock);
        resetn <= 1'b0;
        locked <= 1'b1;
        pending = 1'b0;
        exp_valid = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            load_en   <= 1'b1;
            load_addr <= 20'hF0000 + 20'(i);
            load_data <= prog[i];
            @(posedge clock);
        end
        load_en <= 1'b0;
        repeat (10) @(posedge clock);
        resetn <= 1'b1;
        while (exp_addr_q.size() > 0) step_cycle();
        // Idle tail catches stray writes
        repeat (40) step_cycle();
    endtask

    initial begin
        void'($urandom(45673));
        resetn      = 1'b0;
        locked      = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        errors      = 0;
        cycle_limit = 1000;
        idle_left   = 0;
        idle_on     = 1'b0;
        pending     = 1'b0;
        exp_valid   = 1'b0;
        exp_addr    = '0;
        exp_data    = '0;

        test_name = "mov_push";
        start_program();
        repeat (8) gen_mov_push();
        end_program();
        run_program();

        test_name = "alu_chain";
        start_program();
        repeat (5) gen_alu_chain();
        repeat (8) gen_carry_keep();
        end_program();
        run_program();

        test_name = "branch";
        start_program();
        repeat (16) gen_branch();
        end_program();
        run_program();

        test_name = "push_pop";
        start_program();
        repeat (6) gen_push_pop();
        end_program();
        run_program();

        // Same instruction mix with the core frozen at random
        test_name = "locked";
        start_program();
        repeat (14) begin
            case ($urandom_range(0, 4))
                0: gen_mov_push();
                1: gen_alu_chain();
                2: gen_carry_keep();
                3: gen_branch();
                default: gen_push_pop();
            endcase
        end
        end_program();
        idle_on = 1'b1;
        run_program();
        idle_on = 1'b0;

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/core88_pkg.sv
hdl/alu16.sv
hdl/reg_file.sv
hdl/code_fetch.sv
hdl/stack_port.sv
hdl/bus_arbiter.sv
hdl/sequencer.sv
hdl/core88.sv
tests/mem_model.sv
tests/tb_core88.sv

//--- Makefile
all: run

obj_dir/Vtb_core88: src.f $(shell cat src.f)
	verilator --binary --assert -j 0 --top-module tb_core88 -Mdir obj_dir -f src.f

sim.log: obj_dir/Vtb_core88
	./obj_dir/Vtb_core88 > sim.log 2>&1 || true

run: obj_dir/Vtb_core88
	./obj_dir/Vtb_core88 | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
